//--- src.f
source/lk_pkg.sv
source/lk_stage_if.sv
source/lk_line_ram.sv
source/lk_window_buffer.sv
source/lk_sobel.sv
source/lk_products.sv
source/lk_accumulator.sv
source/lk_flow_top.sv
tests/lk_flow_checker.sv
tests/lk_flow_tb.sv

//--- Bender.yml
package:
  name: lk_flow

sources:
  - source/lk_pkg.sv
  - source/lk_stage_if.sv
  - source/lk_line_ram.sv
  - source/lk_window_buffer.sv
  - source/lk_sobel.sv
  - source/lk_products.sv
  - source/lk_accumulator.sv
  - source/lk_flow_top.sv
  - target: test
    files:
      - tests/lk_flow_checker.sv
      - tests/lk_flow_tb.sv

//--- tests/lk_flow_tb.sv
// ##############################
// lucas-kanade flow testbench
// directed frames checked against a software model of the gradient sums
// ##############################

`timescale 1ns/1ps
`default_nettype none

module lk_flow_tb;

    typedef struct packed {
        lk_pkg::acc_t gx2;
        lk_pkg::acc_t gy2;
        lk_pkg::acc_t gxy;
        lk_pkg::acc_t ex;
        lk_pkg::acc_t ey;
    } sums_t;

    logic         clk;
    logic         rst_n;
    logic         cke;
    logic         img_row_first, img_row_last, img_col_first, img_col_last;
    lk_pkg::ch_t  img_cur, img_prev;
    logic         img_valid;
    lk_pkg::acc_t lk_gx2, lk_gy2, lk_gxy, lk_ex, lk_ey;
    logic         lk_valid;

    sums_t exp_q[$];     // one entry per frame sent
    sums_t got_q[$];     // one entry per lk_valid pulse
    sums_t last_out;
    logic  last_valid;
    logic  have_last;
    logic  edge_live;    // last rising edge could change the outputs

    always #4 clk = ~clk;

    lk_flow_top i_lk_flow_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .cke           (cke),
        .img_row_first (img_row_first),
        .img_row_last  (img_row_last),
        .img_col_first (img_col_first),
        .img_col_last  (img_col_last),
        .img_cur       (img_cur),
        .img_prev      (img_prev),
        .img_valid     (img_valid),
        .lk_gx2        (lk_gx2),
        .lk_gy2        (lk_gy2),
        .lk_gxy        (lk_gxy),
        .lk_ex         (lk_ex),
        .lk_ey         (lk_ey),
        .lk_valid      (lk_valid)
    );

    // ##############################
    // reporting and compares

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_sum(input string name, input lk_pkg::acc_t got, input lk_pkg::acc_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] time %0t %s: got %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] time %0t %s: got %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    // ##############################
    // output monitor

    always @(posedge clk) begin
        edge_live <= cke || !rst_n;
    end

    always @(negedge clk) begin
        if (i_lk_flow_top.u_checker.fail_count != 0) begin
            abort_run("an output assertion in the checker failed");
        end
        if (have_last && !edge_live) begin          // stalled edge, nothing may move
            check_flag("lk_valid", lk_valid, last_valid);
            check_sum("lk_gx2", lk_gx2, last_out.gx2);
            check_sum("lk_gy2", lk_gy2, last_out.gy2);
            check_sum("lk_gxy", lk_gxy, last_out.gxy);
            check_sum("lk_ex", lk_ex, last_out.ex);
            check_sum("lk_ey", lk_ey, last_out.ey);
        end
        if (rst_n && edge_live && lk_valid) begin
            if (got_q.size() >= exp_q.size()) begin
                abort_run("lk_valid pulsed while no frame was pending");
            end
            got_q.push_back({lk_gx2, lk_gy2, lk_gxy, lk_ex, lk_ey});
        end
        last_out   = {lk_gx2, lk_gy2, lk_gxy, lk_ex, lk_ey};
        last_valid = lk_valid;
        have_last  = 1'b1;
    end

    // ##############################
    // reference model

    function automatic int cur_at(input lk_pkg::pixel_t frame[], input int cols,
                                  input int r, input int c);
        return int'(frame[r * cols + c].cur);
    endfunction

    task automatic model_frame(input lk_pkg::pixel_t frame[], input int cols, input int rows,
                               output sums_t sums);
        int r, c, gx, gy, it;
        sums = '0;
        for (r = 1; r < rows - 1; r++) begin
            for (c = 1; c < cols - 1; c++) begin
                gx = cur_at(frame, cols, r - 1, c + 1) + 2 * cur_at(frame, cols, r, c + 1)
                   + cur_at(frame, cols, r + 1, c + 1) - cur_at(frame, cols, r - 1, c - 1)
                   - 2 * cur_at(frame, cols, r, c - 1) - cur_at(frame, cols, r + 1, c - 1);
                gy = cur_at(frame, cols, r + 1, c - 1) + 2 * cur_at(frame, cols, r + 1, c)
                   + cur_at(frame, cols, r + 1, c + 1) - cur_at(frame, cols, r - 1, c - 1)
                   - 2 * cur_at(frame, cols, r - 1, c) - cur_at(frame, cols, r - 1, c + 1);
                it = cur_at(frame, cols, r, c) - int'(frame[r * cols + c].prev);
                sums.gx2 += lk_pkg::acc_t'(gx * gx);
                sums.gy2 += lk_pkg::acc_t'(gy * gy);
                sums.gxy += lk_pkg::acc_t'(gx * gy);
                sums.ex  += lk_pkg::acc_t'(gx * it);
                sums.ey  += lk_pkg::acc_t'(gy * it);
            end
        end
    endtask

    // ##############################
    // stimulus

    function automatic logic pick_cke(input bit stall);
        return stall ? (($urandom % 3) != 0) : 1'b1;
    endfunction

    task automatic idle_cycle(input bit stall);
        @(posedge clk);
        img_valid <= 1'b0;
        cke       <= pick_cke(stall);
    endtask

    task automatic send_frame(input lk_pkg::pixel_t frame[], input int cols, input int rows,
                              input bit stall);
        int   r, c, stalls;
        logic ke;
        for (r = 0; r < rows; r++) begin
            for (c = 0; c < cols; c++) begin
                @(posedge clk);
                img_valid     <= 1'b1;
                img_row_first <= (r == 0);
                img_row_last  <= (r == rows - 1);
                img_col_first <= (c == 0);
                img_col_last  <= (c == cols - 1);
                img_cur       <= frame[r * cols + c].cur;
                img_prev      <= frame[r * cols + c].prev;
                ke     = pick_cke(stall);
                stalls = 0;
                cke   <= ke;
                while (!ke) begin                     // pixel held until an enabled edge
                    @(posedge clk);
                    stalls++;
                    ke   = (stalls >= 3) ? 1'b1 : pick_cke(stall);
                    cke <= ke;
                end
            end
        end
    endtask

    task automatic make_random(output lk_pkg::pixel_t frame[], output int cols, output int rows);
        cols  = 4 + ($urandom % 13);
        rows  = 4 + ($urandom % 9);
        frame = new[cols * rows];
        foreach (frame[i]) begin
            frame[i].cur  = lk_pkg::ch_t'($urandom);
            frame[i].prev = lk_pkg::ch_t'($urandom);
        end
    endtask

    task automatic wait_result(input bit stall);
        int    n;
        sums_t got, exp;
        n = 0;
        while (got_q.size() == 0) begin
            if (n >= 300) begin
                abort_run("result never arrived");
            end
            idle_cycle(stall);
            n++;
        end
        got = got_q.pop_front();
        exp = exp_q.pop_front();
        check_sum("lk_gx2", got.gx2, exp.gx2);
        check_sum("lk_gy2", got.gy2, exp.gy2);
        check_sum("lk_gxy", got.gxy, exp.gxy);
        check_sum("lk_ex", got.ex, exp.ex);
        check_sum("lk_ey", got.ey, exp.ey);
    endtask

    // ##############################
    // directed tests

    task automatic reset_check();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_flag("lk_valid", lk_valid, 1'b0);
        end
    endtask

    task automatic constant_frame();
        lk_pkg::pixel_t frame[];
        frame = new[64];
        foreach (frame[i]) begin
            frame[i].cur  = 8'd100;
            frame[i].prev = 8'd90;
        end
        exp_q.push_back('0);                        // flat image, no gradient
        send_frame(frame, 8, 8, 1'b0);
        wait_result(1'b0);
    endtask

    task automatic ramp_frame();
        lk_pkg::pixel_t frame[];
        sums_t          exp;
        int             k;
        frame = new[120];
        foreach (frame[i]) begin
            frame[i].cur  = lk_pkg::ch_t'(3 * (i % 10));
            frame[i].prev = frame[i].cur;
        end
        exp     = '0;
        exp.gx2 = 576 * 80;                           // gx 24 on 8x10 interior pixels
        exp_q.push_back(exp);
        send_frame(frame, 10, 12, 1'b0);
        for (k = 1; k <= lk_pkg::STAGE_LATENCY + 1; k++) begin
            @(posedge clk);                           // k = 1 takes the last pixel
            img_valid <= 1'b0;
            @(negedge clk);
            check_flag("lk_valid", lk_valid, k == lk_pkg::STAGE_LATENCY);
        end
        wait_result(1'b0);
    endtask

    task automatic check_random_frame(input bit stall);
        lk_pkg::pixel_t frame[];
        int             cols, rows;
        sums_t          exp;
        make_random(frame, cols, rows);
        model_frame(frame, cols, rows, exp);
        exp_q.push_back(exp);
        send_frame(frame, cols, rows, stall);
        wait_result(stall);
    endtask

    task automatic random_frames();
        repeat (5) check_random_frame(1'b0);
    endtask

    task automatic stalled_frame();
        check_random_frame(1'b1);
        repeat (20) idle_cycle(1'b1);
    endtask

    task automatic back_to_back_frames();
        lk_pkg::pixel_t frame_a[], frame_b[];
        int             cols_a, rows_a, cols_b, rows_b;
        sums_t          exp_a, exp_b;
        make_random(frame_a, cols_a, rows_a);
        make_random(frame_b, cols_b, rows_b);
        model_frame(frame_a, cols_a, rows_a, exp_a);
        model_frame(frame_b, cols_b, rows_b, exp_b);
        exp_q.push_back(exp_a);
        exp_q.push_back(exp_b);
        send_frame(frame_a, cols_a, rows_a, 1'b0);
        send_frame(frame_b, cols_b, rows_b, 1'b0);
        wait_result(1'b0);
        wait_result(1'b0);
    endtask

    initial begin
        void'($urandom(32'h349b));
        clk           = 1'b0;
        rst_n         = 1'b0;
        cke           = 1'b1;
        img_valid     = 1'b0;
        img_row_first = 1'b0;
        img_row_last  = 1'b0;
        img_col_first = 1'b0;
        img_col_last  = 1'b0;
        img_cur       = '0;
        img_prev      = '0;
        have_last     = 1'b0;
        reset_check();
        constant_frame();
        ramp_frame();
        random_frames();
        stalled_frame();
        back_to_back_frames();
        repeat (4) idle_cycle(1'b0);
        if (i_lk_flow_top.u_checker.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("an output assertion in the checker failed");
        end
    end

endmodule

`default_nettype wire

//--- tests/lk_flow_checker.sv
// ##############################
// output protocol assertions, bound into the top level
// ##############################

`timescale 1ns/1ps
`default_nettype none

module lk_flow_checker (
    input var logic         clk,
    input var logic         rst_n,
    input var logic         cke,
    input var lk_pkg::acc_t lk_gx2,
    input var lk_pkg::acc_t lk_gy2,
    input var lk_pkg::acc_t lk_gxy,
    input var lk_pkg::acc_t lk_ex,
    input var lk_pkg::acc_t lk_ey,
    input var logic         lk_valid
);

    int unsigned fail_count = 0;

    a_reset_low: assert property (@(posedge clk) !rst_n |=> !lk_valid)
        else begin
            fail_count++;
            $error("lk_valid high after a reset edge");
        end

    // result pulse lasts one enabled cycle
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (cke && lk_valid) |=> !lk_valid)
        else begin
            fail_count++;
            $error("lk_valid high for two enabled cycles");
        end

    a_known_sums: assert property (@(posedge clk) disable iff (!rst_n)
        (cke && lk_valid) |-> !$isunknown({lk_gx2, lk_gy2, lk_gxy, lk_ex, lk_ey}))
        else begin
            fail_count++;
            $error("unknown sum while lk_valid is high");
        end

endmodule

bind lk_flow_top lk_flow_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .cke      (cke),
    .lk_gx2   (lk_gx2),
    .lk_gy2   (lk_gy2),
    .lk_gxy   (lk_gxy),
    .lk_ex    (lk_ex),
    .lk_ey    (lk_ey),
    .lk_valid (lk_valid)
);

`default_nettype wire

//--- source/lk_flow_top.sv
// ##############################
// lucas-kanade gradient sums, top level
// window, sobel, products and frame accumulation
// ##############################

`timescale 1ns/1ps
`default_nettype none

module lk_flow_top (
    input  var logic         clk,
    input  var logic         rst_n,
    input  var logic         cke,
    input  var logic         img_row_first,
    input  var logic         img_row_last,
    input  var logic         img_col_first,
    input  var logic         img_col_last,
    input  var lk_pkg::ch_t  img_cur,
    input  var lk_pkg::ch_t  img_prev,
    input  var logic         img_valid,
    output var lk_pkg::acc_t lk_gx2,
    output var lk_pkg::acc_t lk_gy2,
    output var lk_pkg::acc_t lk_gxy,
    output var lk_pkg::acc_t lk_ex,
    output var lk_pkg::acc_t lk_ey,
    output var logic         lk_valid
);

    lk_pkg::pixel_t img_pixel;

    assign img_pixel = '{cur: img_cur, prev: img_prev};

    lk_stage_if #(.payload_t(lk_pkg::window_t)) win_if  ();
    lk_stage_if #(.payload_t(lk_pkg::grad_t))   grad_if ();
    lk_stage_if #(.payload_t(lk_pkg::prod_t))   prod_if ();

    // ##############################
    // pipeline

    lk_window_buffer u_window_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .cke       (cke),
        .row_first (img_row_first),
        .row_last  (img_row_last),
        .col_first (img_col_first),
        .col_last  (img_col_last),
        .valid     (img_valid),
        .pixel     (img_pixel),
        .win       (win_if.src)
    );

    lk_sobel u_sobel (
        .clk   (clk),
        .rst_n (rst_n),
        .cke   (cke),
        .win   (win_if.snk),
        .grad  (grad_if.src)
    );

    lk_products u_products (
        .clk   (clk),
        .rst_n (rst_n),
        .cke   (cke),
        .grad  (grad_if.snk),
        .prod  (prod_if.src)
    );

    lk_accumulator u_accumulator (
        .clk          (clk),
        .rst_n        (rst_n),
        .cke          (cke),
        .prod         (prod_if.snk),
        .gx2          (lk_gx2),
        .gy2          (lk_gy2),
        .gxy          (lk_gxy),
        .ex           (lk_ex),
        .ey           (lk_ey),
        .result_valid (lk_valid)
    );

endmodule

`default_nettype wire

//--- source/lk_accumulator.sv
// ##############################
// per-frame sums of the gradient products
// ##############################

`timescale 1ns/1ps
`default_nettype none

module lk_accumulator (
    input  var logic         clk,
    input  var logic         rst_n,
    input  var logic         cke,
    lk_stage_if.snk          prod,
    output var lk_pkg::acc_t gx2,
    output var lk_pkg::acc_t gy2,
    output var lk_pkg::acc_t gxy,
    output var lk_pkg::acc_t ex,
    output var lk_pkg::acc_t ey,
    output var logic         result_valid
);

    lk_pkg::acc_t sum_gx2, sum_gy2, sum_gxy, sum_ex, sum_ey;
    lk_pkg::acc_t nxt_gx2, nxt_gy2, nxt_gxy, nxt_ex, nxt_ey;

    function automatic lk_pkg::acc_t step(
        input lk_pkg::acc_t  sum,
        input lk_pkg::calc_t term,
        input logic          load
    );
        lk_pkg::acc_t ext;
        ext = lk_pkg::acc_t'(term);           // sign extend
        return load ? ext : sum + ext;
    endfunction

    // frame_first restarts the sums
    always_comb begin
        nxt_gx2 = step(sum_gx2, prod.payload.gx2, prod.frame_first);
        nxt_gy2 = step(sum_gy2, prod.payload.gy2, prod.frame_first);
        nxt_gxy = step(sum_gxy, prod.payload.gxy, prod.frame_first);
        nxt_ex  = step(sum_ex,  prod.payload.ex,  prod.frame_first);
        nxt_ey  = step(sum_ey,  prod.payload.ey,  prod.frame_first);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_gx2      <= '0;
            sum_gy2      <= '0;
            sum_gxy      <= '0;
            sum_ex       <= '0;
            sum_ey       <= '0;
            gx2          <= '0;
            gy2          <= '0;
            gxy          <= '0;
            ex           <= '0;
            ey           <= '0;
            result_valid <= 1'b0;
        end else if (cke) begin
            result_valid <= prod.valid && prod.frame_last;  // one cycle pulse
            if (prod.valid) begin
                sum_gx2 <= nxt_gx2;
                sum_gy2 <= nxt_gy2;
                sum_gxy <= nxt_gxy;
                sum_ex  <= nxt_ex;
                sum_ey  <= nxt_ey;
                if (prod.frame_last) begin
                    gx2 <= nxt_gx2;
                    gy2 <= nxt_gy2;
                    gxy <= nxt_gxy;
                    ex  <= nxt_ex;
                    ey  <= nxt_ey;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/lk_products.sv
// ##############################
// gradient products, two-stage multiply
// ##############################

`timescale 1ns/1ps
`default_nettype none

module lk_products (
    input  var logic clk,
    input  var logic rst_n,
    input  var logic cke,
    lk_stage_if.snk  grad,
    lk_stage_if.src  prod
);

    lk_pkg::prod_t prod_w, prod_q;
    logic          s1_valid, s1_first, s1_last, s1_active;

    always_comb begin
        prod_w = '0;                          // border items add nothing
        if (grad.active) begin
            prod_w.gx2 = grad.payload.gx * grad.payload.gx;
            prod_w.gy2 = grad.payload.gy * grad.payload.gy;
            prod_w.gxy = grad.payload.gx * grad.payload.gy;
            prod_w.ex  = grad.payload.gx * grad.payload.it;
            prod_w.ey  = grad.payload.gy * grad.payload.it;
        end
    end

    // second register lets the multipliers retime into the dsp
    always_ff @(posedge clk) begin
        if (cke) begin
            prod_q       <= prod_w;
            prod.payload <= prod_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid         <= 1'b0;
            s1_first         <= 1'b0;
            s1_last          <= 1'b0;
            s1_active        <= 1'b0;
            prod.valid       <= 1'b0;
            prod.frame_first <= 1'b0;
            prod.frame_last  <= 1'b0;
            prod.active      <= 1'b0;
        end else if (cke) begin
            s1_valid         <= grad.valid;
            s1_first         <= grad.frame_first;
            s1_last          <= grad.frame_last;
            s1_active        <= grad.active;
            prod.valid       <= s1_valid;
            prod.frame_first <= s1_first;
            prod.frame_last  <= s1_last;
            prod.active      <= s1_active;
        end
    end

endmodule

`default_nettype wire

//--- source/lk_sobel.sv
// ##############################
// sobel gradients and temporal difference
// ##############################

`timescale 1ns/1ps
`default_nettype none

module lk_sobel (
    input  var logic clk,
    input  var logic rst_n,
    input  var logic cke,
    lk_stage_if.snk  win,
    lk_stage_if.src  grad
);

    lk_pkg::sobel_t sum_l, sum_r, sum_t, sum_b;
    lk_pkg::ch_t    c_cur, c_prev;
    logic           s1_valid, s1_first, s1_last, s1_active;

    function automatic lk_pkg::sobel_t tap121(
        input lk_pkg::ch_t a,
        input lk_pkg::ch_t b,
        input lk_pkg::ch_t c
    );
        return lk_pkg::sobel_t'(a) + lk_pkg::sobel_t'(b) * 2 + lk_pkg::sobel_t'(c);
    endfunction

    // ##############################
    // cycle 1, weighted edge sums of the cur channel

    always_ff @(posedge clk) begin
        if (cke) begin
            sum_l  <= tap121(win.payload[0][0].cur, win.payload[1][0].cur,
                             win.payload[2][0].cur);
            sum_r  <= tap121(win.payload[0][2].cur, win.payload[1][2].cur,
                             win.payload[2][2].cur);
            sum_t  <= tap121(win.payload[0][0].cur, win.payload[0][1].cur,
                             win.payload[0][2].cur);
            sum_b  <= tap121(win.payload[2][0].cur, win.payload[2][1].cur,
                             win.payload[2][2].cur);
            c_cur  <= win.payload[1][1].cur;
            c_prev <= win.payload[1][1].prev;
        end
    end

    // ##############################
    // cycle 2, differences

    always_ff @(posedge clk) begin
        if (cke) begin
            grad.payload.gx <= sum_r - sum_l;
            grad.payload.gy <= sum_b - sum_t;
            grad.payload.it <= lk_pkg::sobel_t'(c_cur) - lk_pkg::sobel_t'(c_prev);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid         <= 1'b0;
            s1_first         <= 1'b0;
            s1_last          <= 1'b0;
            s1_active        <= 1'b0;
            grad.valid       <= 1'b0;
            grad.frame_first <= 1'b0;
            grad.frame_last  <= 1'b0;
            grad.active      <= 1'b0;
        end else if (cke) begin
            s1_valid         <= win.valid;
            s1_first         <= win.frame_first;
            s1_last          <= win.frame_last;
            s1_active        <= win.active;
            grad.valid       <= s1_valid;
            grad.frame_first <= s1_first;
            grad.frame_last  <= s1_last;
            grad.active      <= s1_active;
        end
    end

endmodule

`default_nettype wire

//--- source/lk_window_buffer.sv
// ##############################
// 3x3 window buffer
// two chained line memories feed a register window, border items marked
// ##############################

`timescale 1ns/1ps
`default_nettype none

module lk_window_buffer (
    input  var logic           clk,
    input  var logic           rst_n,
    input  var logic           cke,
    input  var logic           row_first,
    input  var logic           row_last,
    input  var logic           col_first,
    input  var logic           col_last,
    input  var logic           valid,
    input  var lk_pkg::pixel_t pixel,
    lk_stage_if.src            win
);

    logic [lk_pkg::COL_BITS-1:0] col_cnt, cur_col, col_d;
    logic [lk_pkg::ROW_BITS-1:0] row_cnt, cur_row;

    lk_pkg::pixel_t       pixel_d;
    lk_pkg::pixel_t       line1_rd;   // one row up
    lk_pkg::pixel_t       line2_rd;   // two rows up
    logic                 valid_d, first_d, last_d, active_d;
    lk_pkg::pixel_t [1:0] top_q;
    lk_pkg::pixel_t [2:0] mid_q, bot_q;
    lk_pkg::window_t      window_w;

    // ##############################
    // position of the arriving pixel

    always_comb begin
        cur_col = col_first ? '0 : col_cnt;
        if (row_first && col_first) begin
            cur_row = '0;
        end else if (col_first) begin
            cur_row = row_cnt + 1'b1;
        end else begin
            cur_row = row_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (cke && valid) begin
            col_cnt <= cur_col + 1'b1;
            row_cnt <= cur_row;
        end
    end

    // ##############################
    // cycle 1, line reads

    lk_line_ram #(
        .word_t  (lk_pkg::pixel_t),
        .depth   (lk_pkg::MAX_COLS)
    ) u_line1 (
        .clk     (clk),
        .cke     (cke),
        .addr    (cur_col),
        .wr_data (pixel),
        .wr_en   (valid),
        .rd_data (line1_rd)
    );

    // advances only with items so its output holds between them
    lk_line_ram #(
        .word_t  (lk_pkg::pixel_t),
        .depth   (lk_pkg::MAX_COLS)
    ) u_line2 (
        .clk     (clk),
        .cke     (cke & valid_d),
        .addr    (col_d),
        .wr_data (line1_rd),
        .wr_en   (1'b1),
        .rd_data (line2_rd)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d  <= 1'b0;
            first_d  <= 1'b0;
            last_d   <= 1'b0;
            active_d <= 1'b0;
        end else if (cke) begin
            valid_d  <= valid;
            first_d  <= valid && row_first && col_first;
            last_d   <= valid && row_last && col_last;
            active_d <= valid && (cur_row >= 2) && (cur_col >= 2);  // centre is up-left
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            pixel_d <= pixel;
            col_d   <= cur_col;
        end
    end

    // ##############################
    // cycle 2, window shift

    always_ff @(posedge clk) begin
        if (cke && valid_d) begin
            top_q <= {line2_rd, top_q[1]};   // right column is the ram output itself
            mid_q <= {line1_rd, mid_q[2:1]};
            bot_q <= {pixel_d, bot_q[2:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win.valid       <= 1'b0;
            win.frame_first <= 1'b0;
            win.frame_last  <= 1'b0;
            win.active      <= 1'b0;
        end else if (cke) begin
            win.valid       <= valid_d;
            win.frame_first <= first_d;
            win.frame_last  <= last_d;
            win.active      <= active_d;
        end
    end

    always_comb begin
        window_w[0][2] = line2_rd;
        window_w[0][1] = top_q[1];
        window_w[0][0] = top_q[0];
        window_w[1]    = mid_q;
        window_w[2]    = bot_q;
    end

    assign win.payload = window_w;

endmodule

`default_nettype wire

//--- source/lk_line_ram.sv
// ##############################
// line memory, read-before-write
// ##############################

`timescale 1ns/1ps
`default_nettype none

module lk_line_ram #(
    parameter type  word_t    = logic [15:0],
    parameter int   depth     = 64,
    localparam int  addr_bits = $clog2(depth)
) (
    input  var logic                 clk,
    input  var logic                 cke,
    input  var logic [addr_bits-1:0] addr,
    input  var word_t                wr_data,
    input  var logic                 wr_en,
    output var word_t                rd_data
);

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (cke) begin
            rd_data <= mem[addr];          // old word, one line back
            if (wr_en) begin
                mem[addr] <= wr_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/lk_stage_if.sv
// ##############################
// pipeline stage link, one item per enabled cycle
// ##############################

`timescale 1ns/1ps
`default_nettype none

interface lk_stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     frame_first;   // item came from the frame's first pixel
    logic     frame_last;    // item came from the frame's last pixel
    logic     active;        // window centre is an interior pixel
    payload_t payload;

    modport src (
        output valid, frame_first, frame_last, active, payload
    );

    modport snk (
        input  valid, frame_first, frame_last, active, payload
    );

endinterface

`default_nettype wire

//--- source/lk_pkg.sv
// ##############################
// lucas-kanade optical flow package
// widths, frame limits and the item types passed between stages
// ##############################

`default_nettype none

package lk_pkg;

    // ##############################
    // sizes

    localparam int CH_BITS       = 8;
    localparam int MAX_COLS      = 64;
    localparam int MAX_ROWS      = 64;
    localparam int COL_BITS      = $clog2(MAX_COLS);
    localparam int ROW_BITS      = $clog2(MAX_ROWS);
    localparam int SOBEL_BITS    = CH_BITS + 4;     // 1-2-1 sums reach 4x a sample
    localparam int CALC_BITS     = SOBEL_BITS * 2;
    localparam int ACC_BITS      = CALC_BITS + 12;  // 4096 products
    localparam int STAGE_LATENCY = 7;

    // ##############################
    // types

    typedef logic [CH_BITS-1:0] ch_t;

    typedef struct packed {
        ch_t cur;
        ch_t prev;
    } pixel_t;

    typedef pixel_t [2:0][2:0] window_t;  // [row][col], row 0 top, col 0 left

    typedef logic signed [SOBEL_BITS-1:0] sobel_t;

    typedef struct packed {
        sobel_t gx;
        sobel_t gy;
        sobel_t it;
    } grad_t;

    typedef logic signed [CALC_BITS-1:0] calc_t;

    typedef struct packed {
        calc_t gx2;
        calc_t gy2;
        calc_t gxy;
        calc_t ex;
        calc_t ey;
    } prod_t;

    typedef logic signed [ACC_BITS-1:0] acc_t;

endpackage

`default_nettype wire
